// File: hw/fpu_defs.svh
`ifndef FPU_DEFS_SVH
`define FPU_DEFS_SVH

// Major opcodes used by the F extension
`define RV32_LOAD_FP        7'b0000111
`define RV32_STORE_FP       7'b0100111
`define RV32_OP_FP          7'b1010011
`define RV32_MADD           7'b1000011
`define RV32_MSUB           7'b1000111
`define RV32_NMSUB          7'b1001011
`define RV32_NMADD          7'b1001111

// funct7 codes for OP_FP, single precision format
`define RV32_FADD_FUN7      7'b0000000
`define RV32_FSUB_FUN7      7'b0000100
`define RV32_FMUL_FUN7      7'b0001000
`define RV32_FDIV_FUN7      7'b0001100
`define RV32_FSQRT_FUN7     7'b0101100
`define RV32_FSGN_FUN7      7'b0010000
`define RV32_FMINMAX_FUN7   7'b0010100
`define RV32_FCVT_W_S_FUN7  7'b1100000
`define RV32_FCVT_S_W_FUN7  7'b1101000
// FCLASS shares this code and funct3 tells them apart
`define RV32_FMV_X_S_FUN7   7'b1110000
`define RV32_FMV_S_X_FUN7   7'b1111000
`define RV32_FCMP_FUN7      7'b1010000

// Sign injection modes
`define RV32_SGNJ_FUN3      3'b000
`define RV32_SGNJN_FUN3     3'b001
`define RV32_SGNJX_FUN3     3'b010

// Compare modes
`define RV32_FLE_FUN3       3'b000
`define RV32_FLT_FUN3       3'b001
`define RV32_FEQ_FUN3       3'b010

// Move and classify group
`define RV32_FMV_FUN3       3'b000
`define RV32_FCLASS_FUN3    3'b001

// Storage sizes
`define FPU_NUM_REGS        32
`define FPU_MEM_WORDS       64
`define FPU_MEM_AW          6

`endif

// File: hw/fpu_pkg.sv
package fpu_pkg;

    // Standard RISC-V R-type field layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] op;
    } instruction_s;

    // Control flags produced by float_decode
    typedef struct packed {
        logic op_writes_rf;
        logic op_writes_frf;
        logic is_mem_op;
        logic is_load_op;
        logic is_store_op;
        logic is_fam_op;
        logic is_fpi_op;
        logic op_reads_rf1;
        logic op_reads_frf1;
        logic op_reads_frf2;
    } f_decode_s;

    // Instruction plus the value of its integer source register
    typedef struct packed {
        instruction_s instr;
        logic [31:0]  rs1_val;
    } fpu_req_s;

    // Completion returned to the host core
    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] int_data;
        logic        writes_rf;
        logic        illegal;
    } fpu_resp_s;

    typedef enum logic [1:0] {
        IDLE,
        EXEC,
        MEM,
        RESP
    } fpu_state_e;

    // Operations handled by the FPI datapath
    typedef enum logic [2:0] {
        FPI_SGNJ,
        FPI_SGNJN,
        FPI_SGNJX,
        FPI_FMV_XW,
        FPI_FMV_WX,
        FPI_FCLASS,
        FPI_FCMP,
        FPI_NONE
    } fpi_op_e;

endpackage

// File: hw/float_decode.sv
`timescale 1ns/10ps
`include "fpu_defs.svh"

module float_decode import fpu_pkg::*; (
    input  instruction_s f_instruction_i,
    output f_decode_s    f_decode_o
);

    logic [6:0] op;
    logic [6:0] f7;

    assign op = f_instruction_i.op;
    assign f7 = f_instruction_i.funct7;

    // Integer register file writes
    always_comb begin
        f_decode_o.op_writes_rf = 1'b0;
        if (op == `RV32_OP_FP) begin
            unique case (f7)
                `RV32_FCVT_W_S_FUN7, `RV32_FMV_X_S_FUN7, `RV32_FCMP_FUN7:
                    f_decode_o.op_writes_rf = 1'b1;
                default:
                    f_decode_o.op_writes_rf = 1'b0;
            endcase
        end
    end

    // Memory ops
    always_comb begin
        f_decode_o.is_load_op  = (op == `RV32_LOAD_FP);
        f_decode_o.is_store_op = (op == `RV32_STORE_FP);
        f_decode_o.is_mem_op   = f_decode_o.is_load_op | f_decode_o.is_store_op;
    end

    // Floating point register file writes
    always_comb begin
        unique case (op)
            `RV32_LOAD_FP, `RV32_MADD, `RV32_MSUB, `RV32_NMADD, `RV32_NMSUB:
                f_decode_o.op_writes_frf = 1'b1;
            `RV32_OP_FP: begin
                unique case (f7)
                    `RV32_FADD_FUN7, `RV32_FSUB_FUN7, `RV32_FMUL_FUN7,
                    `RV32_FDIV_FUN7, `RV32_FSQRT_FUN7, `RV32_FMINMAX_FUN7,
                    `RV32_FSGN_FUN7, `RV32_FMV_S_X_FUN7, `RV32_FCVT_S_W_FUN7:
                        f_decode_o.op_writes_frf = 1'b1;
                    default:
                        f_decode_o.op_writes_frf = 1'b0;
                endcase
            end
            default:
                f_decode_o.op_writes_frf = 1'b0;
        endcase
    end

    // Arithmetic unit ops whose fused forms carry rs3 in funct7
    always_comb begin
        unique case (op)
            `RV32_MADD, `RV32_MSUB, `RV32_NMADD, `RV32_NMSUB:
                f_decode_o.is_fam_op = 1'b1;
            `RV32_OP_FP: begin
                unique case (f7)
                    `RV32_FADD_FUN7, `RV32_FSUB_FUN7, `RV32_FMUL_FUN7,
                    `RV32_FDIV_FUN7, `RV32_FSQRT_FUN7, `RV32_FMINMAX_FUN7:
                        f_decode_o.is_fam_op = 1'b1;
                    default:
                        f_decode_o.is_fam_op = 1'b0;
                endcase
            end
            default:
                f_decode_o.is_fam_op = 1'b0;
        endcase
    end

    // Ops for the FPI datapath
    always_comb begin
        f_decode_o.is_fpi_op = 1'b0;
        if (op == `RV32_OP_FP) begin
            unique case (f7)
                `RV32_FSGN_FUN7, `RV32_FCVT_W_S_FUN7, `RV32_FCVT_S_W_FUN7,
                `RV32_FMV_S_X_FUN7, `RV32_FMV_X_S_FUN7, `RV32_FCMP_FUN7:
                    f_decode_o.is_fpi_op = 1'b1;
                default:
                    f_decode_o.is_fpi_op = 1'b0;
            endcase
        end
    end

    // Integer source replaces floating point port 1 for these
    always_comb begin
        f_decode_o.op_reads_rf1 = (op == `RV32_OP_FP) &&
                                  (f7 == `RV32_FCVT_S_W_FUN7 || f7 == `RV32_FMV_S_X_FUN7);
        unique case (op)
            `RV32_MADD, `RV32_MSUB, `RV32_NMADD, `RV32_NMSUB:
                f_decode_o.op_reads_frf1 = 1'b1;
            `RV32_OP_FP:
                f_decode_o.op_reads_frf1 = ~f_decode_o.op_reads_rf1;
            default:
                f_decode_o.op_reads_frf1 = 1'b0;
        endcase
    end

    // Second floating point read port
    always_comb begin
        unique case (op)
            `RV32_STORE_FP, `RV32_MADD, `RV32_MSUB, `RV32_NMADD, `RV32_NMSUB:
                f_decode_o.op_reads_frf2 = 1'b1;
            `RV32_OP_FP: begin
                unique case (f7)
                    `RV32_FSQRT_FUN7, `RV32_FCVT_W_S_FUN7, `RV32_FMV_X_S_FUN7,
                    `RV32_FCVT_S_W_FUN7, `RV32_FMV_S_X_FUN7:
                        f_decode_o.op_reads_frf2 = 1'b0;
                    default:
                        f_decode_o.op_reads_frf2 = 1'b1;
                endcase
            end
            default:
                f_decode_o.op_reads_frf2 = 1'b0;
        endcase
    end

endmodule

// File: hw/fp_regfile.sv
`timescale 1ns/10ps
`include "fpu_defs.svh"

module fp_regfile (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic [4:0]  raddr1_i,
    input  logic [4:0]  raddr2_i,
    output logic [31:0] rdata1_o,
    output logic [31:0] rdata2_o,
    input  logic        we_i,
    input  logic [4:0]  waddr_i,
    input  logic [31:0] wdata_i
);

    logic [31:0] regs [`FPU_NUM_REGS];

    // f0 is an ordinary register in the F extension
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `FPU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = regs[raddr1_i];
    assign rdata2_o = regs[raddr2_i];

endmodule

// File: hw/fpi_unit.sv
`timescale 1ns/10ps
`include "fpu_defs.svh"

module fpi_unit import fpu_pkg::*; (
    input  instruction_s instr_i,
    input  logic [31:0]  frs1_i,
    input  logic [31:0]  frs2_i,
    input  logic [31:0]  rs1_val_i,
    output logic [31:0]  int_result_o,
    output logic [31:0]  fp_result_o,
    output logic         fpi_illegal_o
);

    fpi_op_e     fpi_op;
    logic [9:0]  class_mask;
    logic        a_exp_max, a_exp_zero, a_man_zero;
    logic        a_nan, b_nan, both_zero, f_eq, f_lt;
    logic        cmp_bit;

    // Operation select
    always_comb begin
        fpi_op        = FPI_NONE;
        fpi_illegal_o = 1'b0;
        if (instr_i.op == `RV32_OP_FP) begin
            unique case (instr_i.funct7)
                `RV32_FSGN_FUN7: begin
                    unique case (instr_i.funct3)
                        `RV32_SGNJ_FUN3:  fpi_op = FPI_SGNJ;
                        `RV32_SGNJN_FUN3: fpi_op = FPI_SGNJN;
                        `RV32_SGNJX_FUN3: fpi_op = FPI_SGNJX;
                        default:          fpi_illegal_o = 1'b1;
                    endcase
                end
                `RV32_FMV_X_S_FUN7: begin
                    unique case (instr_i.funct3)
                        `RV32_FMV_FUN3:    fpi_op = FPI_FMV_XW;
                        `RV32_FCLASS_FUN3: fpi_op = FPI_FCLASS;
                        default:           fpi_illegal_o = 1'b1;
                    endcase
                end
                `RV32_FMV_S_X_FUN7: begin
                    if (instr_i.funct3 == `RV32_FMV_FUN3) fpi_op = FPI_FMV_WX;
                    else fpi_illegal_o = 1'b1;
                end
                `RV32_FCMP_FUN7: begin
                    if (instr_i.funct3 inside {`RV32_FLE_FUN3, `RV32_FLT_FUN3, `RV32_FEQ_FUN3})
                        fpi_op = FPI_FCMP;
                    else
                        fpi_illegal_o = 1'b1;
                end
                // No conversion hardware in this slice
                `RV32_FCVT_W_S_FUN7, `RV32_FCVT_S_W_FUN7:
                    fpi_illegal_o = 1'b1;
                default:
                    fpi_op = FPI_NONE;
            endcase
        end
    end

    // Classify frs1
    assign a_exp_max  = &frs1_i[30:23];
    assign a_exp_zero = ~|frs1_i[30:23];
    assign a_man_zero = ~|frs1_i[22:0];

    always_comb begin
        class_mask    = '0;
        class_mask[0] = frs1_i[31] & a_exp_max & a_man_zero;
        class_mask[1] = frs1_i[31] & ~a_exp_max & ~a_exp_zero;
        class_mask[2] = frs1_i[31] & a_exp_zero & ~a_man_zero;
        class_mask[3] = frs1_i[31] & a_exp_zero & a_man_zero;
        class_mask[4] = ~frs1_i[31] & a_exp_zero & a_man_zero;
        class_mask[5] = ~frs1_i[31] & a_exp_zero & ~a_man_zero;
        class_mask[6] = ~frs1_i[31] & ~a_exp_max & ~a_exp_zero;
        class_mask[7] = ~frs1_i[31] & a_exp_max & a_man_zero;
        // Quiet bit separates signaling from quiet NaN
        class_mask[8] = a_exp_max & ~a_man_zero & ~frs1_i[22];
        class_mask[9] = a_exp_max & frs1_i[22];
    end

    // NaN compares false and zeros of either sign are equal
    assign a_nan     = a_exp_max & ~a_man_zero;
    assign b_nan     = (&frs2_i[30:23]) & (|frs2_i[22:0]);
    assign both_zero = ~|{frs1_i[30:0], frs2_i[30:0]};
    assign f_eq      = ~a_nan & ~b_nan & ((frs1_i == frs2_i) | both_zero);

    always_comb begin
        if (a_nan || b_nan || both_zero)
            f_lt = 1'b0;
        else if (frs1_i[31] != frs2_i[31])
            f_lt = frs1_i[31];
        else if (frs1_i[31])
            f_lt = frs1_i[30:0] > frs2_i[30:0];
        else
            f_lt = frs1_i[30:0] < frs2_i[30:0];
    end

    always_comb begin
        unique case (instr_i.funct3)
            `RV32_FEQ_FUN3: cmp_bit = f_eq;
            `RV32_FLT_FUN3: cmp_bit = f_lt;
            default:        cmp_bit = f_lt | f_eq;
        endcase
    end

    // Result muxes
    always_comb begin
        int_result_o = '0;
        fp_result_o  = '0;
        unique case (fpi_op)
            FPI_SGNJ:   fp_result_o  = {frs2_i[31], frs1_i[30:0]};
            FPI_SGNJN:  fp_result_o  = {~frs2_i[31], frs1_i[30:0]};
            FPI_SGNJX:  fp_result_o  = {frs1_i[31] ^ frs2_i[31], frs1_i[30:0]};
            FPI_FMV_WX: fp_result_o  = rs1_val_i;
            FPI_FMV_XW: int_result_o = frs1_i;
            FPI_FCLASS: int_result_o = {22'd0, class_mask};
            FPI_FCMP:   int_result_o = {31'd0, cmp_bit};
            default:    int_result_o = '0;
        endcase
    end

endmodule

// File: hw/fp_scratchpad.sv
`timescale 1ns/10ps
`include "fpu_defs.svh"

module fp_scratchpad (
    input  logic                   clk_i,
    input  logic [`FPU_MEM_AW-1:0] addr_i,
    input  logic                   we_i,
    input  logic [31:0]            wdata_i,
    output logic [31:0]            rdata_o
);

    logic [31:0] mem [`FPU_MEM_WORDS];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
    end

    // Read data follows the address by one cycle
    always_ff @(posedge clk_i) begin
        rdata_o <= mem[addr_i];
    end

endmodule

// File: hw/fpu_issue_fsm.sv
`timescale 1ns/10ps
`include "fpu_defs.svh"

module fpu_issue_fsm import fpu_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   req_valid_i,
    input  fpu_req_s               req_i,
    output logic                   req_ready_o,
    output logic                   resp_valid_o,
    output fpu_resp_s              resp_o,
    input  logic                   resp_ready_i,
    output instruction_s           instr_o,
    output logic [31:0]            rs1_val_o,
    input  f_decode_s              dec_i,
    input  logic                   fpi_illegal_i,
    input  logic [31:0]            int_result_i,
    input  logic [31:0]            fp_result_i,
    input  logic [31:0]            frs2_i,
    input  logic [31:0]            mem_rdata_i,
    output logic                   frf_we_o,
    output logic [4:0]             frf_waddr_o,
    output logic [31:0]            frf_wdata_o,
    output logic [`FPU_MEM_AW-1:0] mem_addr_o,
    output logic                   mem_we_o,
    output logic [31:0]            mem_wdata_o
);

    fpu_state_e   state_q;
    instruction_s instr_q;
    logic [31:0]  rs1_val_q;
    fpu_resp_s    resp_q;
    logic         legal;
    logic         in_exec;
    logic [11:0]  imm;
    logic [31:0]  eff_addr;

    assign in_exec = (state_q == EXEC);
    assign legal   = dec_i.is_mem_op | (dec_i.is_fpi_op & ~fpi_illegal_i);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            unique case (state_q)
                IDLE: if (req_valid_i) state_q <= EXEC;
                EXEC: state_q <= (legal && dec_i.is_load_op) ? MEM : RESP;
                MEM:  state_q <= RESP;
                RESP: if (resp_ready_i) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // Request capture and response build
    always_ff @(posedge clk_i) begin
        if (req_ready_o && req_valid_i) begin
            instr_q   <= req_i.instr;
            rs1_val_q <= req_i.rs1_val;
        end
        if (in_exec) begin
            resp_q.rd        <= instr_q.rd;
            resp_q.writes_rf <= legal & dec_i.op_writes_rf;
            resp_q.int_data  <= (legal && dec_i.op_writes_rf) ? int_result_i : '0;
            resp_q.illegal   <= ~legal;
        end
    end

    // I-type offset for loads, S-type for stores
    assign imm      = dec_i.is_store_op ? {instr_q.funct7, instr_q.rd}
                                        : {instr_q.funct7, instr_q.rs2};
    assign eff_addr = rs1_val_q + {{20{imm[11]}}, imm};

    assign mem_addr_o  = eff_addr[`FPU_MEM_AW+1:2];
    assign mem_we_o    = in_exec & legal & dec_i.is_store_op;
    assign mem_wdata_o = frs2_i;

    // Loads write back from the scratchpad in MEM
    assign frf_we_o    = (state_q == MEM) |
                         (in_exec & legal & dec_i.op_writes_frf & ~dec_i.is_load_op);
    assign frf_waddr_o = instr_q.rd;
    assign frf_wdata_o = dec_i.is_load_op ? mem_rdata_i : fp_result_i;

    assign req_ready_o  = (state_q == IDLE);
    assign resp_valid_o = (state_q == RESP);
    assign resp_o       = resp_q;
    assign instr_o      = instr_q;
    assign rs1_val_o    = rs1_val_q;

endmodule

// File: hw/fpu_top.sv
`timescale 1ns/10ps
`include "fpu_defs.svh"

module fpu_top import fpu_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      req_valid_i,
    input  fpu_req_s  req_i,
    output logic      req_ready_o,
    output logic      resp_valid_o,
    output fpu_resp_s resp_o,
    input  logic      resp_ready_i
);

    instruction_s           instr;
    f_decode_s              dec;
    logic [31:0]            rs1_val, frs1, frs2, int_result, fp_result, mem_rdata;
    logic                   fpi_illegal, frf_we, mem_we;
    logic [4:0]             frf_waddr;
    logic [31:0]            frf_wdata, mem_wdata;
    logic [`FPU_MEM_AW-1:0] mem_addr;

    float_decode u_decode (
        .f_instruction_i (instr),
        .f_decode_o      (dec)
    );

    fp_regfile u_frf (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .raddr1_i (instr.rs1),
        .raddr2_i (instr.rs2),
        .rdata1_o (frs1),
        .rdata2_o (frs2),
        .we_i     (frf_we),
        .waddr_i  (frf_waddr),
        .wdata_i  (frf_wdata)
    );

    fpi_unit u_fpi (
        .instr_i       (instr),
        .frs1_i        (frs1),
        .frs2_i        (frs2),
        .rs1_val_i     (rs1_val),
        .int_result_o  (int_result),
        .fp_result_o   (fp_result),
        .fpi_illegal_o (fpi_illegal)
    );

    fp_scratchpad u_mem (
        .clk_i   (clk_i),
        .addr_i  (mem_addr),
        .we_i    (mem_we),
        .wdata_i (mem_wdata),
        .rdata_o (mem_rdata)
    );

    fpu_issue_fsm u_fsm (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .req_valid_i   (req_valid_i),
        .req_i         (req_i),
        .req_ready_o   (req_ready_o),
        .resp_valid_o  (resp_valid_o),
        .resp_o        (resp_o),
        .resp_ready_i  (resp_ready_i),
        .instr_o       (instr),
        .rs1_val_o     (rs1_val),
        .dec_i         (dec),
        .fpi_illegal_i (fpi_illegal),
        .int_result_i  (int_result),
        .fp_result_i   (fp_result),
        .frs2_i        (frs2),
        .mem_rdata_i   (mem_rdata),
        .frf_we_o      (frf_we),
        .frf_waddr_o   (frf_waddr),
        .frf_wdata_o   (frf_wdata),
        .mem_addr_o    (mem_addr),
        .mem_we_o      (mem_we),
        .mem_wdata_o   (mem_wdata)
    );

endmodule

// File: dv/fpu_tb_model.svh
`ifndef FPU_TB_MODEL_SVH
`define FPU_TB_MODEL_SVH

// Reference behavior of the F extension ops on raw 32-bit words

function automatic logic is_nan(input logic [31:0] w);
    return (w[30:23] == 8'hff) && (w[22:0] != 23'd0);
endfunction

// One bit per IEEE class in the RISC-V bit order
function automatic logic [31:0] fclass_word(input logic [31:0] w);
    logic [31:0] res;
    logic        m_zero;
    int          idx;
    m_zero = (w[22:0] == 23'd0);
    if (w[30:23] == 8'hff && !m_zero)
        idx = w[22] ? 9 : 8;
    else if (w[30:23] == 8'hff)
        idx = w[31] ? 0 : 7;
    else if (w[30:23] == 8'h00 && m_zero)
        idx = w[31] ? 3 : 4;
    else if (w[30:23] == 8'h00)
        idx = w[31] ? 2 : 5;
    else
        idx = w[31] ? 1 : 6;
    res = 32'd0;
    res[idx] = 1'b1;
    return res;
endfunction

// Signed key that orders non-NaN values and maps both zeros to 0
function automatic logic signed [32:0] order_key(input logic [31:0] w);
    logic signed [32:0] mag;
    mag = {2'b00, w[30:0]};
    return w[31] ? -mag : mag;
endfunction

function automatic logic [31:0] fcmp_word(input logic [31:0] a, input logic [31:0] b,
                                          input logic [2:0] f3);
    logic signed [32:0] ka;
    logic signed [32:0] kb;
    ka = order_key(a);
    kb = order_key(b);
    if (is_nan(a) || is_nan(b))
        return 32'd0;
    case (f3)
        `RV32_FEQ_FUN3: return {31'd0, ka == kb};
        `RV32_FLT_FUN3: return {31'd0, ka < kb};
        default:        return {31'd0, ka <= kb};
    endcase
endfunction

function automatic logic [31:0] sign_inject(input logic [31:0] a, input logic [31:0] b,
                                            input logic [2:0] f3);
    logic s;
    case (f3)
        `RV32_SGNJ_FUN3:  s = b[31];
        `RV32_SGNJN_FUN3: s = ~b[31];
        default:          s = a[31] ^ b[31];
    endcase
    return {s, a[30:0]};
endfunction

`endif

// File: dv/fpu_tb.sv
`timescale 1ns/10ps
`include "fpu_defs.svh"

module fpu_tb import fpu_pkg::*; ();

    localparam int NUM_INSTR = 400;
    localparam int CLK_NS    = 20;
    // NaN, infinity, zero, subnormal and normal patterns for FMV.W.X
    localparam logic [31:0] SPECIALS [10] = '{32'h7fc00000, 32'h7f800001, 32'hffc00001,
        32'h7f800000, 32'hff800000, 32'h00000000, 32'h80000000, 32'h00000001,
        32'h807fffff, 32'hbf800000};

    logic      clk_i, rst_n_i, req_valid_i, req_ready_o, resp_valid_o, resp_ready_i;
    fpu_req_s  req_i;
    fpu_resp_s resp_o;

    // Shadow state of the model
    logic [31:0] frf [32];
    logic [31:0] smem [64];
    logic        smem_ok [64];

    fpu_resp_s exp_resp, held_resp;
    int        exp_lat, accept_cyc, cyc, done_count;
    logic      busy, resp_shown, req_taken;

    `include "fpu_tb_model.svh"

    fpu_top i_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_NS / 2) clk_i = ~clk_i;
    end

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "Simulation stopped at %0t", $time);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
            stop_with_error("Response check failed");
        end
    endtask

    // Expected completion and shadow state update for one accepted request
    task automatic model_step(input fpu_req_s r);
        instruction_s in;
        logic [31:0]  a, b, addr;
        logic [11:0]  imm;
        in = r.instr;
        a = frf[in.rs1];
        b = frf[in.rs2];
        exp_resp = '0;
        exp_resp.rd = in.rd;
        exp_lat = 2;
        case (in.op)
            `RV32_LOAD_FP: begin
                imm = {in.funct7, in.rs2};
                addr = r.rs1_val + {{20{imm[11]}}, imm};
                frf[in.rd] = smem[addr[7:2]];
                exp_lat = 3;
            end
            `RV32_STORE_FP: begin
                imm = {in.funct7, in.rd};
                addr = r.rs1_val + {{20{imm[11]}}, imm};
                smem[addr[7:2]] = b;
                smem_ok[addr[7:2]] = 1'b1;
            end
            `RV32_OP_FP: begin
                case ({in.funct7, in.funct3})
                    {`RV32_FSGN_FUN7, `RV32_SGNJ_FUN3}, {`RV32_FSGN_FUN7, `RV32_SGNJN_FUN3},
                    {`RV32_FSGN_FUN7, `RV32_SGNJX_FUN3}:
                        frf[in.rd] = sign_inject(a, b, in.funct3);
                    {`RV32_FMV_S_X_FUN7, `RV32_FMV_FUN3}:
                        frf[in.rd] = r.rs1_val;
                    {`RV32_FMV_X_S_FUN7, `RV32_FMV_FUN3}:
                        exp_resp.int_data = a;
                    {`RV32_FMV_X_S_FUN7, `RV32_FCLASS_FUN3}:
                        exp_resp.int_data = fclass_word(a);
                    {`RV32_FCMP_FUN7, `RV32_FEQ_FUN3}, {`RV32_FCMP_FUN7, `RV32_FLT_FUN3},
                    {`RV32_FCMP_FUN7, `RV32_FLE_FUN3}:
                        exp_resp.int_data = fcmp_word(a, b, in.funct3);
                    default:
                        exp_resp.illegal = 1'b1;
                endcase
                exp_resp.writes_rf = !exp_resp.illegal &&
                    (in.funct7 == `RV32_FMV_X_S_FUN7 || in.funct7 == `RV32_FCMP_FUN7);
            end
            default: exp_resp.illegal = 1'b1;
        endcase
    endtask

    task automatic build_request(output fpu_req_s r);
        instruction_s in;
        int           kind, w;
        logic [11:0]  imm;
        kind = $urandom_range(0, 99);
        in.rd = $urandom_range(0, 7);
        in.rs1 = $urandom_range(0, 7);
        in.rs2 = $urandom_range(0, 7);
        in.funct3 = `RV32_FMV_FUN3;
        in.funct7 = `RV32_FMV_X_S_FUN7;
        in.op = `RV32_OP_FP;
        r.rs1_val = $urandom();
        if (kind < 10) begin
            case ($urandom_range(0, 2))
                0: in.funct7 = `RV32_FADD_FUN7;
                1: in.funct7 = $urandom_range(0, 1) ? `RV32_FCVT_W_S_FUN7 : `RV32_FCVT_S_W_FUN7;
                default: in.op = 7'b0110011;
            endcase
        end else if (kind < 25) begin
            in.funct7 = `RV32_FMV_S_X_FUN7;
            if ($urandom_range(0, 1))
                r.rs1_val = SPECIALS[$urandom_range(0, 9)];
        end else if (kind < 35) begin
            // FMV.X.W is the default encoding
        end else if (kind < 50) begin
            in.funct7 = `RV32_FSGN_FUN7;
            in.funct3 = $urandom_range(0, 2);
        end else if (kind < 60) begin
            in.funct3 = `RV32_FCLASS_FUN3;
        end else if (kind < 75) begin
            in.funct7 = `RV32_FCMP_FUN7;
            in.funct3 = $urandom_range(0, 2);
        end else begin
            // Small word index with loads only from words already stored
            w = $urandom_range(0, 7);
            imm = $urandom_range(0, 63) - 32;
            r.rs1_val = w * 4 + $urandom_range(0, 3) - {{20{imm[11]}}, imm};
            in.funct3 = 3'b010;
            if (kind < 88 || !smem_ok[w]) begin
                in.op = `RV32_STORE_FP;
                {in.funct7, in.rd} = imm;
            end else begin
                in.op = `RV32_LOAD_FP;
                {in.funct7, in.rs2} = imm;
            end
        end
        r.instr = in;
    endtask

    // Monitor samples mid-cycle where all DUT outputs are settled
    always @(negedge clk_i) begin
        cyc++;
        if (rst_n_i) begin
            check_value("req_ready_o", req_ready_o, !busy);
            if (resp_valid_o && !busy) begin
                stop_with_error("A response arrived with no outstanding request");
            end else if (resp_valid_o) begin
                if (!resp_shown) begin
                    check_value("response latency", cyc - accept_cyc, exp_lat);
                    check_value("resp_o.rd", resp_o.rd, exp_resp.rd);
                    check_value("resp_o.int_data", resp_o.int_data, exp_resp.int_data);
                    check_value("resp_o.writes_rf", resp_o.writes_rf, exp_resp.writes_rf);
                    check_value("resp_o.illegal", resp_o.illegal, exp_resp.illegal);
                    held_resp = resp_o;
                    resp_shown = 1'b1;
                end
                check_value("resp_o under back-pressure", resp_o, held_resp);
                if (resp_ready_i) begin
                    busy = 1'b0;
                    resp_shown = 1'b0;
                    done_count++;
                end
            end else if (busy && cyc - accept_cyc >= exp_lat) begin
                stop_with_error("The DUT did not raise resp_valid_o in time");
            end
            if (req_valid_i && req_ready_o) begin
                model_step(req_i);
                accept_cyc = cyc;
                busy = 1'b1;
                req_taken = 1'b1;
            end
        end
    end

    initial begin
        #(NUM_INSTR * 40 * CLK_NS);
        stop_with_error("Watchdog timeout, the DUT stopped completing instructions");
    end

    initial begin
        int sent;
        void'($urandom(88925));
        rst_n_i = 1'b0;
        req_valid_i = 1'b0;
        req_i = '0;
        resp_ready_i = 1'b0;
        {cyc, done_count, sent} = '0;
        {busy, resp_shown, req_taken} = '0;
        for (int i = 0; i < 64; i++) begin
            smem_ok[i] = 1'b0;
        end
        for (int i = 0; i < 32; i++) begin
            frf[i] = '0;
        end
        repeat (4) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;
        while (done_count < NUM_INSTR) begin
            @(posedge clk_i);
            #2;
            resp_ready_i = ($urandom_range(0, 99) < 70);
            if (req_taken) begin
                req_taken = 1'b0;
                req_valid_i = 1'b0;
                sent++;
            end
            if (!req_valid_i && sent < NUM_INSTR && $urandom_range(0, 3) != 0) begin
                build_request(req_i);
                req_valid_i = 1'b1;
            end
        end
        $display("Test OK");
        $finish;
    end

endmodule

// File: sources.f
+incdir+hw
+incdir+dv
hw/fpu_pkg.sv
hw/float_decode.sv
hw/fp_regfile.sv
hw/fpi_unit.sv
hw/fp_scratchpad.sv
hw/fpu_issue_fsm.sv
hw/fpu_top.sv
dv/fpu_tb.sv
